/* hdl/fifo_geom_pkg.sv */
package fifo_geom_pkg;

  // default build: 8-bit writes, 32-bit reads, 16 narrow words
  localparam int DEF_W_DATA_W = 8;
  localparam int DEF_R_DATA_W = 32;
  localparam int DEF_ADDR_W   = 4;

  function automatic int max_w(input int a, input int b);
    return (a > b) ? a : b;
  endfunction

  function automatic int min_w(input int a, input int b);
    return (a < b) ? a : b;
  endfunction

  // log2 of the wide/narrow ratio, ratio is a power of two
  function automatic int ratio_log2(input int w_data_w, input int r_data_w);
    return $clog2(max_w(w_data_w, r_data_w) / min_w(w_data_w, r_data_w));
  endfunction

  // the wider side addresses fewer, larger words
  function automatic int side_addr_w(input int addr_w, input int side_w, input int other_w);
    if (side_w > other_w) begin
      return addr_w - ratio_log2(side_w, other_w);
    end
    return addr_w;
  endfunction

  typedef logic [DEF_W_DATA_W-1:0] wr_word_t;
  typedef logic [DEF_R_DATA_W-1:0] rd_word_t;

  // fill level in narrow units, one extra bit so that full is representable
  typedef logic [DEF_ADDR_W:0] level_t;

endpackage

/* hdl/gray_code_pkg.sv */
package gray_code_pkg;

  // widest pointer handled, callers zero-extend and keep the low bits
  localparam int PTR_MAX_W = 16;

  function automatic logic [PTR_MAX_W-1:0] to_gray(input logic [PTR_MAX_W-1:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  // each binary bit is the xor of all gray bits at or above it
  function automatic logic [PTR_MAX_W-1:0] from_gray(input logic [PTR_MAX_W-1:0] gray);
    logic [PTR_MAX_W-1:0] bin;
    bin[PTR_MAX_W-1] = gray[PTR_MAX_W-1];
    for (int i = PTR_MAX_W - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

/* hdl/fifo_mem_if.sv */
`timescale 1ns/10ps

interface fifo_mem_if #(
  parameter int DATA_W = 32,
  parameter int ADDR_W = 2,
  parameter int LANES  = 4
) ();

  // write port, one enable per narrow lane
  logic [LANES-1:0]  w_en;
  logic [ADDR_W-1:0] w_addr;
  logic [DATA_W-1:0] w_data;

  // read port, data registered inside the RAM
  logic              r_en;
  logic [ADDR_W-1:0] r_addr;
  logic [DATA_W-1:0] r_data;

  modport conv (
    output w_en, w_addr, w_data, r_en, r_addr,
    input  r_data
  );

  modport ram (
    input  w_en, w_addr, w_data, r_en, r_addr,
    output r_data
  );

endinterface

/* hdl/fifo_wr_ctrl.sv */
`timescale 1ns/10ps

module fifo_wr_ctrl #(
  parameter int W_DATA_W = 8,
  parameter int R_DATA_W = 32,
  parameter int ADDR_W   = 4,
  localparam int WA = fifo_geom_pkg::side_addr_w(ADDR_W, W_DATA_W, R_DATA_W),
  localparam int RA = fifo_geom_pkg::side_addr_w(ADDR_W, R_DATA_W, W_DATA_W)
) (
  input  logic            w_clk_i,
  input  logic            rst_n_i,
  input  logic            w_en_i,
  input  logic [RA:0]     rd_ptr_gray_i,
  output logic [WA:0]     wr_ptr_gray_o,
  output logic [WA-1:0]   w_addr_o,
  output logic            w_accept_o,
  output logic [ADDR_W:0] w_level_o,
  output logic            w_full_o,
  output logic            w_empty_o
);
  import fifo_geom_pkg::*;
  import gray_code_pkg::*;

  localparam int RL      = ratio_log2(W_DATA_W, R_DATA_W);
  localparam int W_SHIFT = (W_DATA_W > R_DATA_W) ? RL : 0;
  localparam int R_SHIFT = (R_DATA_W > W_DATA_W) ? RL : 0;
  localparam logic [ADDR_W:0] FIFO_SIZE = (ADDR_W + 1)'(1) << ADDR_W;
  localparam logic [ADDR_W:0] W_INCR    = (ADDR_W + 1)'(1) << W_SHIFT;

  logic [WA:0]          wr_ptr_bin;
  logic [WA:0]          wr_ptr_next;
  logic [PTR_MAX_W-1:0] wr_gray_wide;
  logic [RA:0]          rd_gray_meta;
  logic [RA:0]          rd_gray_sync;
  logic [PTR_MAX_W-1:0] rd_bin_wide;
  logic [ADDR_W:0]      wr_norm;
  logic [ADDR_W:0]      rd_norm;
  logic [ADDR_W:0]      level;

  assign w_accept_o   = w_en_i & ~w_full_o;
  assign wr_ptr_next  = wr_ptr_bin + 1'b1;
  assign wr_gray_wide = to_gray(PTR_MAX_W'(wr_ptr_next));

  // binary and gray pointer advance together on an accepted write
  always_ff @(posedge w_clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_bin    <= '0;
      wr_ptr_gray_o <= '0;
    end else if (w_accept_o) begin
      wr_ptr_bin    <= wr_ptr_next;
      wr_ptr_gray_o <= wr_gray_wide[WA:0];
    end
  end

  // two-flop synchronizer for the read pointer
  always_ff @(posedge w_clk_i) begin
    if (!rst_n_i) begin
      rd_gray_meta <= '0;
      rd_gray_sync <= '0;
    end else begin
      rd_gray_meta <= rd_ptr_gray_i;
      rd_gray_sync <= rd_gray_meta;
    end
  end

  assign rd_bin_wide = from_gray(PTR_MAX_W'(rd_gray_sync));

  // both pointers in narrow units
  assign wr_norm = (ADDR_W + 1)'(wr_ptr_bin) << W_SHIFT;
  assign rd_norm = (ADDR_W + 1)'(rd_bin_wide[RA:0]) << R_SHIFT;
  assign level   = wr_norm - rd_norm;

  assign w_addr_o  = wr_ptr_bin[WA-1:0];
  assign w_level_o = level;
  assign w_empty_o = (level < W_INCR);
  // full once there is no room for one more write word
  assign w_full_o  = ((FIFO_SIZE - level) < W_INCR);

endmodule

/* hdl/fifo_rd_ctrl.sv */
`timescale 1ns/10ps

module fifo_rd_ctrl #(
  parameter int W_DATA_W = 8,
  parameter int R_DATA_W = 32,
  parameter int ADDR_W   = 4,
  localparam int WA = fifo_geom_pkg::side_addr_w(ADDR_W, W_DATA_W, R_DATA_W),
  localparam int RA = fifo_geom_pkg::side_addr_w(ADDR_W, R_DATA_W, W_DATA_W)
) (
  input  logic            r_clk_i,
  input  logic            rst_n_i,
  input  logic            r_en_i,
  input  logic [WA:0]     wr_ptr_gray_i,
  output logic [RA:0]     rd_ptr_gray_o,
  output logic [RA-1:0]   r_addr_o,
  output logic            r_accept_o,
  output logic [ADDR_W:0] r_level_o,
  output logic            r_full_o,
  output logic            r_empty_o
);
  import fifo_geom_pkg::*;
  import gray_code_pkg::*;

  localparam int RL      = ratio_log2(W_DATA_W, R_DATA_W);
  localparam int W_SHIFT = (W_DATA_W > R_DATA_W) ? RL : 0;
  localparam int R_SHIFT = (R_DATA_W > W_DATA_W) ? RL : 0;
  localparam logic [ADDR_W:0] FIFO_SIZE = (ADDR_W + 1)'(1) << ADDR_W;
  localparam logic [ADDR_W:0] R_INCR    = (ADDR_W + 1)'(1) << R_SHIFT;

  logic [RA:0]          rd_ptr_bin;
  logic [RA:0]          rd_ptr_next;
  logic [PTR_MAX_W-1:0] rd_gray_wide;
  logic [WA:0]          wr_gray_meta;
  logic [WA:0]          wr_gray_sync;
  logic [PTR_MAX_W-1:0] wr_bin_wide;
  logic [ADDR_W:0]      wr_norm;
  logic [ADDR_W:0]      rd_norm;
  logic [ADDR_W:0]      level;

  assign r_accept_o   = r_en_i & ~r_empty_o;
  assign rd_ptr_next  = rd_ptr_bin + 1'b1;
  assign rd_gray_wide = to_gray(PTR_MAX_W'(rd_ptr_next));

  // the read pointer moves only when a word actually leaves
  always_ff @(posedge r_clk_i) begin
    if (!rst_n_i) begin
      rd_ptr_bin    <= '0;
      rd_ptr_gray_o <= '0;
    end else if (r_accept_o) begin
      rd_ptr_bin    <= rd_ptr_next;
      rd_ptr_gray_o <= rd_gray_wide[RA:0];
    end
  end

  // write pointer crosses into r_clk through two flops
  always_ff @(posedge r_clk_i) begin
    if (!rst_n_i) begin
      wr_gray_meta <= '0;
      wr_gray_sync <= '0;
    end else begin
      wr_gray_meta <= wr_ptr_gray_i;
      wr_gray_sync <= wr_gray_meta;
    end
  end

  assign wr_bin_wide = from_gray(PTR_MAX_W'(wr_gray_sync));

  assign wr_norm = (ADDR_W + 1)'(wr_bin_wide[WA:0]) << W_SHIFT;
  assign rd_norm = (ADDR_W + 1)'(rd_ptr_bin) << R_SHIFT;
  assign level   = wr_norm - rd_norm;

  assign r_addr_o  = rd_ptr_bin[RA-1:0];
  assign r_level_o = level;
  // empty until a whole read word is present
  assign r_empty_o = (level < R_INCR);
  assign r_full_o  = ((FIFO_SIZE - level) < R_INCR);

endmodule

/* hdl/asym_width_conv.sv */
`timescale 1ns/10ps

module asym_width_conv #(
  parameter int W_DATA_W = 8,
  parameter int R_DATA_W = 32,
  parameter int ADDR_W   = 4,
  localparam int WA = fifo_geom_pkg::side_addr_w(ADDR_W, W_DATA_W, R_DATA_W),
  localparam int RA = fifo_geom_pkg::side_addr_w(ADDR_W, R_DATA_W, W_DATA_W)
) (
  input  logic                w_clk_i,
  input  logic                r_clk_i,
  input  logic                rst_n_i,
  input  logic                w_accept_i,
  input  logic [WA-1:0]       w_addr_i,
  input  logic [W_DATA_W-1:0] w_data_i,
  input  logic                r_accept_i,
  input  logic [RA-1:0]       r_addr_i,
  output logic [R_DATA_W-1:0] r_data_o,
  fifo_mem_if.conv            mem
);
  import fifo_geom_pkg::*;

  localparam int RL    = ratio_log2(W_DATA_W, R_DATA_W);
  localparam int LANES = 1 << RL;

  logic                r_accept_q;
  logic [R_DATA_W-1:0] r_word;

  generate
    if (W_DATA_W < R_DATA_W) begin : g_narrow_write
      // row from the upper bits, lane from the low bits, lowest lane first
      assign mem.w_addr = w_addr_i[WA-1:RL];
      assign mem.w_en   = w_accept_i ? (LANES'(1) << w_addr_i[RL-1:0]) : '0;
      assign mem.w_data = {LANES{w_data_i}};
    end else begin : g_wide_write
      assign mem.w_addr = w_addr_i;
      assign mem.w_en   = {LANES{w_accept_i}};
      assign mem.w_data = w_data_i;
    end

    if (R_DATA_W < W_DATA_W) begin : g_narrow_read
      localparam int LANE_W = min_w(W_DATA_W, R_DATA_W);
      logic [RL-1:0] lane_sel_q;

      // lane index follows the RAM read by one cycle
      always_ff @(posedge r_clk_i) begin
        if (r_accept_i) begin
          lane_sel_q <= r_addr_i[RL-1:0];
        end
      end

      assign mem.r_addr = r_addr_i[RA-1:RL];
      assign r_word     = mem.r_data[lane_sel_q*LANE_W +: LANE_W];
    end else begin : g_wide_read
      assign mem.r_addr = r_addr_i;
      assign r_word     = mem.r_data;
    end
  endgenerate

  assign mem.r_en = r_accept_i;

  always_ff @(posedge r_clk_i) begin
    if (!rst_n_i) begin
      r_accept_q <= 1'b0;
    end else begin
      r_accept_q <= r_accept_i;
    end
  end

  // output word is held between accepted reads
  always_ff @(posedge r_clk_i) begin
    if (!rst_n_i) begin
      r_data_o <= '0;
    end else if (r_accept_q) begin
      r_data_o <= r_word;
    end
  end

endmodule

/* hdl/dp_ram.sv */
`timescale 1ns/10ps

module dp_ram #(
  parameter int DATA_W = 32,
  parameter int ADDR_W = 2,
  parameter int LANES  = 4
) (
  input  logic    w_clk_i,
  input  logic    r_clk_i,
  fifo_mem_if.ram mem
);

  localparam int LANE_W = DATA_W / LANES;
  localparam int DEPTH  = 1 << ADDR_W;

  logic [DATA_W-1:0] mem_q [DEPTH];

  // byte-lane style write, only enabled lanes change
  always_ff @(posedge w_clk_i) begin
    for (int l = 0; l < LANES; l++) begin
      if (mem.w_en[l]) begin
        mem_q[mem.w_addr][l*LANE_W +: LANE_W] <= mem.w_data[l*LANE_W +: LANE_W];
      end
    end
  end

  // registered read in the read clock domain
  always_ff @(posedge r_clk_i) begin
    if (mem.r_en) begin
      mem.r_data <= mem_q[mem.r_addr];
    end
  end

endmodule

/* hdl/async_fifo_top.sv */
`timescale 1ns/10ps

module async_fifo_top #(
  parameter int W_DATA_W = fifo_geom_pkg::DEF_W_DATA_W,
  parameter int R_DATA_W = fifo_geom_pkg::DEF_R_DATA_W,
  parameter int ADDR_W   = fifo_geom_pkg::DEF_ADDR_W
) (
  input  logic                w_clk_i,
  input  logic                r_clk_i,
  input  logic                rst_n_i,
  input  logic                w_en_i,
  input  logic [W_DATA_W-1:0] w_data_i,
  output logic                w_full_o,
  output logic                w_empty_o,
  output logic [ADDR_W:0]     w_level_o,
  input  logic                r_en_i,
  output logic [R_DATA_W-1:0] r_data_o,
  output logic                r_empty_o,
  output logic                r_full_o,
  output logic [ADDR_W:0]     r_level_o
);
  import fifo_geom_pkg::*;

  localparam int RL     = ratio_log2(W_DATA_W, R_DATA_W);
  localparam int WA     = side_addr_w(ADDR_W, W_DATA_W, R_DATA_W);
  localparam int RA     = side_addr_w(ADDR_W, R_DATA_W, W_DATA_W);
  // RAM rows are one wide word each
  localparam int RAM_W  = max_w(W_DATA_W, R_DATA_W);
  localparam int RAM_AW = ADDR_W - RL;
  localparam int LANES  = 1 << RL;

  logic [WA:0]   wr_ptr_gray;
  logic [RA:0]   rd_ptr_gray;
  logic [WA-1:0] w_addr;
  logic [RA-1:0] r_addr;
  logic          w_accept;
  logic          r_accept;

  fifo_mem_if #(.DATA_W(RAM_W), .ADDR_W(RAM_AW), .LANES(LANES)) fifo_mem_if_i ();

  fifo_wr_ctrl #(.W_DATA_W(W_DATA_W), .R_DATA_W(R_DATA_W), .ADDR_W(ADDR_W)) fifo_wr_ctrl_i (
    .w_clk_i      (w_clk_i),
    .rst_n_i      (rst_n_i),
    .w_en_i       (w_en_i),
    .rd_ptr_gray_i(rd_ptr_gray),
    .wr_ptr_gray_o(wr_ptr_gray),
    .w_addr_o     (w_addr),
    .w_accept_o   (w_accept),
    .w_level_o    (w_level_o),
    .w_full_o     (w_full_o),
    .w_empty_o    (w_empty_o)
  );

  fifo_rd_ctrl #(.W_DATA_W(W_DATA_W), .R_DATA_W(R_DATA_W), .ADDR_W(ADDR_W)) fifo_rd_ctrl_i (
    .r_clk_i      (r_clk_i),
    .rst_n_i      (rst_n_i),
    .r_en_i       (r_en_i),
    .wr_ptr_gray_i(wr_ptr_gray),
    .rd_ptr_gray_o(rd_ptr_gray),
    .r_addr_o     (r_addr),
    .r_accept_o   (r_accept),
    .r_level_o    (r_level_o),
    .r_full_o     (r_full_o),
    .r_empty_o    (r_empty_o)
  );

  asym_width_conv #(.W_DATA_W(W_DATA_W), .R_DATA_W(R_DATA_W), .ADDR_W(ADDR_W)) asym_width_conv_i (
    .w_clk_i   (w_clk_i),
    .r_clk_i   (r_clk_i),
    .rst_n_i   (rst_n_i),
    .w_accept_i(w_accept),
    .w_addr_i  (w_addr),
    .w_data_i  (w_data_i),
    .r_accept_i(r_accept),
    .r_addr_i  (r_addr),
    .r_data_o  (r_data_o),
    .mem       (fifo_mem_if_i.conv)
  );

  dp_ram #(.DATA_W(RAM_W), .ADDR_W(RAM_AW), .LANES(LANES)) dp_ram_i (
    .w_clk_i(w_clk_i),
    .r_clk_i(r_clk_i),
    .mem    (fifo_mem_if_i.ram)
  );

endmodule

/* tests/tb_clk_gen.sv */
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter real PERIOD_NS = 40.0,
  parameter real PHASE_NS  = 0.0
) (
  output logic clk_o
);

  // starts low, first rising edge half a period after the phase offset
  initial begin
    clk_o = 1'b0;
    #(PHASE_NS);
    forever begin
      #(PERIOD_NS / 2.0);
      clk_o = ~clk_o;
    end
  end

endmodule

/* tests/tb_async_fifo.sv */
`timescale 1ns/10ps

module tb_async_fifo;
  import fifo_geom_pkg::*;

  localparam int LANES         = DEF_R_DATA_W / DEF_W_DATA_W;
  localparam int DEPTH         = 1 << DEF_ADDR_W;
  localparam int NUM_ENTRIES   = 12;
  localparam int SETTLE_CYCLES = 10;

  typedef enum logic [1:0] {WRITE_N, READ_N, SETTLE} op_e;

  typedef struct {
    string  name;
    op_e    op;
    int     count;
    logic   exp_w_full;
    logic   exp_r_empty;
    level_t exp_level;
  } entry_t;

  logic     w_clk;
  logic     r_clk;
  logic     rst_n_i;
  logic     w_en_i;
  wr_word_t w_data_i;
  logic     w_full_o;
  logic     w_empty_o;
  level_t   w_level_o;
  logic     r_en_i;
  rd_word_t r_data_o;
  logic     r_empty_o;
  logic     r_full_o;
  level_t   r_level_o;

  entry_t   stim_tab [NUM_ENTRIES];
  int       n_entries;
  logic     table_ready;
  integer   seed;
  wr_word_t model_q [$];
  rd_word_t last_rd;
  int       word_errs;
  int       level_errs;
  int       flag_errs;

  tb_clk_gen #(.PERIOD_NS(40.0), .PHASE_NS(0.0))  w_clk_gen_i (.clk_o(w_clk));
  // read clock runs 13 ns behind the write clock
  tb_clk_gen #(.PERIOD_NS(40.0), .PHASE_NS(13.0)) r_clk_gen_i (.clk_o(r_clk));

  async_fifo_top async_fifo_top_i (
    .w_clk_i  (w_clk),
    .r_clk_i  (r_clk),
    .rst_n_i  (rst_n_i),
    .w_en_i   (w_en_i),
    .w_data_i (w_data_i),
    .w_full_o (w_full_o),
    .w_empty_o(w_empty_o),
    .w_level_o(w_level_o),
    .r_en_i   (r_en_i),
    .r_data_o (r_data_o),
    .r_empty_o(r_empty_o),
    .r_full_o (r_full_o),
    .r_level_o(r_level_o)
  );

  task automatic check_word(input string test, input rd_word_t exp, input rd_word_t act);
    if (act !== exp) begin
      $display("[ERROR] %0s r_data_o: expected %h, actual %h", test, exp, act);
      word_errs++;
    end
  endtask

  task automatic check_level(input string test, input string sig, input level_t exp,
                             input level_t act);
    if (act !== exp) begin
      $display("[ERROR] %0s %0s: expected %0d, actual %0d", test, sig, exp, act);
      level_errs++;
    end
  endtask

  task automatic check_flag(input string test, input string sig, input logic exp,
                            input logic act);
    if (act !== exp) begin
      $display("[ERROR] %0s %0s: expected %b, actual %b", test, sig, exp, act);
      flag_errs++;
    end
  endtask

  task automatic add_entry(input string name, input op_e op, input int count,
                           input logic w_full, input logic r_empty, input int level);
    stim_tab[n_entries].name        = name;
    stim_tab[n_entries].op          = op;
    stim_tab[n_entries].count       = count;
    stim_tab[n_entries].exp_w_full  = w_full;
    stim_tab[n_entries].exp_r_empty = r_empty;
    stim_tab[n_entries].exp_level   = level_t'(level);
    n_entries++;
  endtask

  task automatic load_table();
    n_entries = 0;
    //        name              op       cnt  w_full r_empty level
    add_entry("reset_state",    SETTLE,   0,  1'b0,  1'b1,   0);
    add_entry("pack_write",     WRITE_N,  8,  1'b0,  1'b0,   8);
    add_entry("pack_read",      READ_N,   2,  1'b0,  1'b1,   0);
    add_entry("fill_write",     WRITE_N, 18,  1'b1,  1'b0,  16);
    add_entry("fill_settle",    SETTLE,   5,  1'b1,  1'b0,  16);
    add_entry("fill_read",      READ_N,   4,  1'b0,  1'b1,   0);
    add_entry("underflow_read", READ_N,   1,  1'b0,  1'b1,   0);
    add_entry("part_write",     WRITE_N,  6,  1'b0,  1'b0,   6);
    add_entry("part_settle",    SETTLE,   5,  1'b0,  1'b0,   6);
    // second read finds only two bytes and is dropped
    add_entry("part_read",      READ_N,   2,  1'b0,  1'b1,   2);
    add_entry("tail_write",     WRITE_N,  2,  1'b0,  1'b0,   4);
    add_entry("tail_read",      READ_N,   1,  1'b0,  1'b1,   0);
    table_ready = 1'b1;
  endtask

  // back-to-back writes where the model keeps only what fits
  task automatic write_words(input int n);
    logic [31:0] rnd;
    for (int i = 0; i < n; i++) begin
      @(posedge w_clk);
      rnd = $random(seed);
      w_en_i   <= 1'b1;
      w_data_i <= rnd[DEF_W_DATA_W-1:0];
      if (model_q.size() < DEPTH) begin
        model_q.push_back(rnd[DEF_W_DATA_W-1:0]);
      end
    end
    @(posedge w_clk);
    w_en_i <= 1'b0;
  endtask

  // one read strobe with data one edge after the accepting edge
  task automatic read_word(input string test);
    @(posedge r_clk);
    r_en_i <= 1'b1;
    @(posedge r_clk);
    r_en_i <= 1'b0;
    if (model_q.size() >= LANES) begin
      for (int l = 0; l < LANES; l++) begin
        last_rd[l*DEF_W_DATA_W +: DEF_W_DATA_W] = model_q.pop_front();
      end
    end
    @(posedge r_clk);
    @(negedge r_clk);
    check_word(test, last_rd, r_data_o);
  endtask

  task automatic settle_and_check(input int idx);
    string  name;
    int     cnt;
    level_t cnt_l;
    name  = stim_tab[idx].name;
    cnt   = model_q.size();
    cnt_l = level_t'(cnt);
    repeat (SETTLE_CYCLES) @(posedge w_clk);
    @(negedge w_clk);
    check_flag(name, "w_full_o", stim_tab[idx].exp_w_full, w_full_o);
    check_flag(name, "r_empty_o", stim_tab[idx].exp_r_empty, r_empty_o);
    check_level(name, "w_level_o", stim_tab[idx].exp_level, w_level_o);
    check_level(name, "r_level_o", stim_tab[idx].exp_level, r_level_o);
    if (stim_tab[idx].op == SETTLE) begin
      // both sides agree with the model and the flags follow the word sizes
      check_level(name, "w_level_o/model", cnt_l, w_level_o);
      check_level(name, "r_level_o/model", cnt_l, r_level_o);
      check_flag(name, "w_empty_o", cnt < 1, w_empty_o);
      check_flag(name, "w_full_o/model", (DEPTH - cnt) < 1, w_full_o);
      check_flag(name, "r_empty_o/model", cnt < LANES, r_empty_o);
      check_flag(name, "r_full_o", (DEPTH - cnt) < LANES, r_full_o);
      check_word(name, last_rd, r_data_o);
    end
  endtask

  initial begin
    realtime limit_ns;
    int      total;
    total = 0;
    wait (table_ready);
    for (int i = 0; i < n_entries; i++) begin
      total += stim_tab[i].count + SETTLE_CYCLES;
    end
    limit_ns = 2.0 * 80.0 * total;
    #(limit_ns);
    $display("timeout: the run did not finish within %0.0f ns", limit_ns);
    $display("Errors found");
    $finish;
  end

  initial begin
    int total_errs;
    rst_n_i     = 1'b0;
    w_en_i      = 1'b0;
    w_data_i    = '0;
    r_en_i      = 1'b0;
    last_rd     = '0;
    word_errs   = 0;
    level_errs  = 0;
    flag_errs   = 0;
    table_ready = 1'b0;
    seed        = 32'h72c04516;
    load_table();

    // reset spans 5 edges of each clock
    fork
      repeat (5) @(posedge w_clk);
      repeat (5) @(posedge r_clk);
    join
    rst_n_i <= 1'b1;

    for (int i = 0; i < n_entries; i++) begin
      case (stim_tab[i].op)
        WRITE_N: write_words(stim_tab[i].count);
        READ_N: begin
          for (int k = 0; k < stim_tab[i].count; k++) begin
            read_word(stim_tab[i].name);
          end
        end
        SETTLE:  repeat (stim_tab[i].count) @(posedge w_clk);
        default: ;
      endcase
      settle_and_check(i);
    end

    total_errs = word_errs + level_errs + flag_errs;
    $display("error count %0d (data %0d, level %0d, flag %0d)", total_errs, word_errs,
             level_errs, flag_errs);
    if (total_errs == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* tb.f */
hdl/fifo_geom_pkg.sv
hdl/gray_code_pkg.sv
hdl/fifo_mem_if.sv
hdl/fifo_wr_ctrl.sv
hdl/fifo_rd_ctrl.sv
hdl/asym_width_conv.sv
hdl/dp_ram.sv
hdl/async_fifo_top.sv
tests/tb_clk_gen.sv
tests/tb_async_fifo.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the async FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_EXE=tb_async_fifo_sim
LOG_FILE=sim.log

verilator --binary --timing \
  --top-module tb_async_fifo \
  -f tb.f \
  --Mdir "$BUILD_DIR" \
  -o "$SIM_EXE"
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

"./$BUILD_DIR/$SIM_EXE" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ "$run_status" -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx "No errors" "$LOG_FILE"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
